// File: common/segre_defines.svh
`ifndef SEGRE_DEFINES_SVH
`define SEGRE_DEFINES_SVH

// Data path and address width
`define WORD_SIZE 32
`define WORD_BYTES (`WORD_SIZE / 8)

// Store buffer depth and its pointer width
`define NUM_SB_ENTRIES 4
`define SB_ENTRY_BITS 2

// Direct-mapped cache with one word per line
`define CACHE_LINES 16
`define ADDR_BYTE_BITS 2
`define ADDR_INDEX_BITS 4
`define ADDR_TAG_BITS (`WORD_SIZE - `ADDR_INDEX_BITS - `ADDR_BYTE_BITS)

`endif

// File: common/segre_pkg.sv
`default_nettype none

`include "segre_defines.svh"

package segre_pkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_data_type_e;

    // Field view of an address, tag on top
    typedef struct packed {
        logic [`ADDR_TAG_BITS-1:0]   tag;
        logic [`ADDR_INDEX_BITS-1:0] index;
        logic [`ADDR_BYTE_BITS-1:0]  offset;
    } mem_addr_fields_t;

    // Same address word, seen raw or split for the cache
    typedef union packed {
        logic [`WORD_SIZE-1:0] raw;
        mem_addr_fields_t      fields;
    } mem_addr_u;

    // Bytes of a word touched by an access of this size at this offset
    function automatic logic [`WORD_BYTES-1:0] byte_mask(
        input memop_data_type_e           size,
        input logic [`ADDR_BYTE_BITS-1:0] offset
    );
        logic [`WORD_BYTES-1:0] base;
        case (size)
            BYTE:    base = 'b1;
            HALF:    base = 'b11;
            default: base = '1;
        endcase
        // Accesses are naturally aligned, so nothing spills past byte 3
        return base << offset;
    endfunction

endpackage : segre_pkg

`default_nettype wire

// File: source/segre_mem_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module segre_mem_req_stage (
    input  wire logic                         clk_i,
    input  wire logic                         rsn_i,
    // Request from the previous stage
    input  wire logic                         is_load_i,
    input  wire logic                         is_store_i,
    input  wire logic                         is_alu_i,
    input  wire logic [`WORD_SIZE-1:0]        addr_i,
    input  wire logic [`WORD_SIZE-1:0]        data_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    input  wire logic                         stall_i,
    // Line fill
    input  wire logic                         fill_valid_i,
    input  segre_pkg::mem_addr_u              fill_addr_i,
    // Registered request
    output logic                              is_load_o,
    output logic                              is_store_o,
    output logic                              is_alu_o,
    output segre_pkg::mem_addr_u              addr_o,
    output logic [`WORD_SIZE-1:0]             data_o,
    output segre_pkg::memop_data_type_e       data_type_o,
    output logic                              cache_hit_o
);

    // Tag store and per-line valid bits
    logic [`ADDR_TAG_BITS-1:0] tag_array [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]   line_valid;

    // Operation strobes, bubbles go in while stalled
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            is_load_o  <= 1'b0;
            is_store_o <= 1'b0;
            is_alu_o   <= 1'b0;
        end else begin
            is_load_o  <= is_load_i && !stall_i;
            is_store_o <= is_store_i && !stall_i;
            is_alu_o   <= is_alu_i && !stall_i;
        end
    end

    // Operands follow the strobes, only meaningful with a strobe high
    always_ff @(posedge clk_i) begin
        addr_o.raw  <= addr_i;
        data_o      <= data_i;
        data_type_o <= data_type_i;
    end

    // A fill is the only way a line turns valid
    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            line_valid <= '0;
        end else if (fill_valid_i) begin
            line_valid[fill_addr_i.fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            tag_array[fill_addr_i.fields.index] <= fill_addr_i.fields.tag;
        end
    end

    // Hit check on the registered address
    assign cache_hit_o = line_valid[addr_o.fields.index]
                      && (tag_array[addr_o.fields.index] == addr_o.fields.tag);

    // Upstream never issues two kinds of operation at once
    assert property (@(posedge clk_i) disable iff (!rsn_i)
        $onehot0({is_load_i, is_store_i, is_alu_i}));

endmodule : segre_mem_req_stage

`default_nettype wire

// File: store_buffer/segre_store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module segre_store_buffer (
    input  wire logic                         clk_i,
    input  wire logic                         rsn_i,
    // Registered request with at most one strobe high
    input  wire logic                         is_load_i,
    input  wire logic                         is_store_i,
    input  wire logic                         is_alu_i,
    input  segre_pkg::mem_addr_u              addr_i,
    input  wire logic [`WORD_SIZE-1:0]        data_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    // Cache tag hit for the request
    input  wire logic                         is_hit_i,
    // Bytes forwarded to a load
    output logic [`WORD_BYTES-1:0]            forward_mask_o,
    output logic [`WORD_SIZE-1:0]             forward_data_o,
    // Entry leaving toward the data array
    output logic                              drain_we_o,
    output segre_pkg::mem_addr_u              drain_addr_o,
    output logic [`WORD_SIZE-1:0]             drain_data_o,
    output segre_pkg::memop_data_type_e       drain_type_o,
    output logic                              is_draining_o
);

    import segre_pkg::*;

    typedef enum logic {
        NOT_DRAINING,
        DRAINING
    } sb_state_e;

    // Entry payload with data already on its byte lanes
    mem_addr_u             sb_addr [`NUM_SB_ENTRIES];
    logic [`WORD_SIZE-1:0] sb_data [`NUM_SB_ENTRIES];
    memop_data_type_e      sb_type [`NUM_SB_ENTRIES];

    logic [`NUM_SB_ENTRIES-1:0] sb_valid;
    logic [`NUM_SB_ENTRIES-1:0] valid_next;
    logic [`NUM_SB_ENTRIES-1:0] idx_match;
    logic [`SB_ENTRY_BITS-1:0]  wr_ptr;
    logic [`SB_ENTRY_BITS-1:0]  rd_ptr;

    sb_state_e sb_state;
    sb_state_e sb_next_state;

    logic full;
    logic empty;
    logic sb_write;
    logic drain;
    logic sb_hit;

    assign full  = &sb_valid;
    assign empty = ~|sb_valid;

    // Only stores that hit in the cache are kept
    assign sb_write = is_store_i && is_hit_i && !full;

    // One entry leaves per ALU slot, or every cycle of a blocking drain
    assign drain = !empty && ((sb_state == DRAINING) || is_alu_i);

    // Index compare against every valid entry
    always_comb begin
        for (int i = 0; i < `NUM_SB_ENTRIES; i++) begin
            idx_match[i] = sb_valid[i]
                        && (sb_addr[i].fields.index == addr_i.fields.index);
        end
    end

    assign sb_hit = |idx_match;

    // Valid bits after this edge
    always_comb begin
        valid_next = sb_valid;
        if (drain) begin
            valid_next[rd_ptr] = 1'b0;
        end
        if (sb_write) begin
            valid_next[wr_ptr] = 1'b1;
        end
    end

    always_comb begin
        sb_next_state = sb_state;
        case (sb_state)
            NOT_DRAINING: begin
                // Full buffer, or a load miss on a line with pending stores
                if (full || (is_load_i && !is_hit_i && sb_hit)) begin
                    sb_next_state = DRAINING;
                end
            end
            DRAINING: begin
                // Leave on the edge that empties the buffer
                if (valid_next == '0) begin
                    sb_next_state = NOT_DRAINING;
                end
            end
            default: sb_next_state = NOT_DRAINING;
        endcase
    end

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            sb_state <= NOT_DRAINING;
            sb_valid <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            sb_state <= sb_next_state;
            sb_valid <= valid_next;
            if (sb_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (drain) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sb_write) begin
            sb_addr[wr_ptr] <= addr_i;
            sb_data[wr_ptr] <= data_i << {addr_i.fields.offset, 3'b000};
            sb_type[wr_ptr] <= data_type_i;
        end
    end

    // Walk from oldest to newest so younger stores win per byte
    always_comb begin
        logic [`SB_ENTRY_BITS-1:0] pos;
        logic [`WORD_BYTES-1:0]    lanes;
        forward_mask_o = '0;
        forward_data_o = '0;
        for (int k = 0; k < `NUM_SB_ENTRIES; k++) begin
            pos   = rd_ptr + `SB_ENTRY_BITS'(k);
            lanes = byte_mask(sb_type[pos], sb_addr[pos].fields.offset);
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (idx_match[pos] && lanes[b]) begin
                    forward_mask_o[b]        = 1'b1;
                    forward_data_o[8*b +: 8] = sb_data[pos][8*b +: 8];
                end
            end
        end
    end

    // Oldest entry goes to the data array
    assign drain_we_o   = drain;
    assign drain_addr_o = sb_addr[rd_ptr];
    assign drain_data_o = sb_data[rd_ptr];
    assign drain_type_o = sb_type[rd_ptr];

    // Also high in the cycle a store is about to fill the last slot,
    // so the request behind it is held rather than lost
    assign is_draining_o = (sb_state == DRAINING) || full || (sb_write && &valid_next);

    // The stall keeps hitting stores away from a full buffer
    assert property (@(posedge clk_i) disable iff (!rsn_i)
        full |-> !(is_store_i && is_hit_i));

    // Read pointer only moves past an entry that holds a store
    assert property (@(posedge clk_i) disable iff (!rsn_i)
        drain |-> sb_valid[rd_ptr]);

endmodule : segre_store_buffer

`default_nettype wire

// File: source/segre_dcache_data.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module segre_dcache_data (
    input  wire logic                         clk_i,
    input  wire logic                         rsn_i,
    // Read port for the request stage
    input  wire logic [`ADDR_INDEX_BITS-1:0]  rd_index_i,
    // Store buffer drain, data already on its byte lanes
    input  wire logic                         drain_we_i,
    input  segre_pkg::mem_addr_u              drain_addr_i,
    input  wire logic [`WORD_SIZE-1:0]        drain_data_i,
    input  segre_pkg::memop_data_type_e       drain_type_i,
    // Whole-line fill
    input  wire logic                         fill_valid_i,
    input  segre_pkg::mem_addr_u              fill_addr_i,
    input  wire logic [`WORD_SIZE-1:0]        fill_data_i,
    output logic [`WORD_SIZE-1:0]             rd_data_o
);

    import segre_pkg::*;

    logic [`WORD_SIZE-1:0]  data_array [`CACHE_LINES];
    logic [`WORD_BYTES-1:0] drain_be;

    // Byte enables of the drained store
    assign drain_be = byte_mask(drain_type_i, drain_addr_i.fields.offset);

    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            data_array[fill_addr_i.fields.index] <= fill_data_i;
        end else if (drain_we_i) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (drain_be[b]) begin
                    data_array[drain_addr_i.fields.index][8*b +: 8] <= drain_data_i[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read at the registered request index
    assign rd_data_o = data_array[rd_index_i];

    // Fills only come in while the pipeline is idle
    assert property (@(posedge clk_i) disable iff (!rsn_i)
        !(drain_we_i && fill_valid_i));

endmodule : segre_dcache_data

`default_nettype wire

// File: source/segre_mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module segre_mem_wb_stage (
    input  wire logic                         clk_i,
    input  wire logic                         rsn_i,
    input  wire logic                         is_load_i,
    input  wire logic                         cache_hit_i,
    input  segre_pkg::mem_addr_u              addr_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    input  wire logic [`WORD_SIZE-1:0]        cache_data_i,
    input  wire logic [`WORD_BYTES-1:0]       forward_mask_i,
    input  wire logic [`WORD_SIZE-1:0]        forward_data_i,
    output logic                              load_valid_o,
    output logic                              load_miss_o,
    output logic [`WORD_SIZE-1:0]             load_data_o
);

    import segre_pkg::*;

    logic [`WORD_SIZE-1:0] merged;
    logic [`WORD_SIZE-1:0] shifted;
    logic [`WORD_SIZE-1:0] load_word;

    // Pending store bytes override the cache word
    always_comb begin
        merged = cache_data_i;
        for (int b = 0; b < `WORD_BYTES; b++) begin
            if (forward_mask_i[b]) begin
                merged[8*b +: 8] = forward_data_i[8*b +: 8];
            end
        end
    end

    // Bring the addressed byte down to bit 0
    assign shifted = merged >> {addr_i.fields.offset, 3'b000};

    // Zero extension only, signed loads are not supported
    always_comb begin
        case (data_type_i)
            BYTE:    load_word = {{(`WORD_SIZE-8){1'b0}}, shifted[7:0]};
            HALF:    load_word = {{(`WORD_SIZE-16){1'b0}}, shifted[15:0]};
            default: load_word = shifted;
        endcase
    end

    always_ff @(posedge clk_i, negedge rsn_i) begin
        if (!rsn_i) begin
            load_valid_o <= 1'b0;
            load_miss_o  <= 1'b0;
        end else begin
            load_valid_o <= is_load_i;
            load_miss_o  <= is_load_i && !cache_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        load_data_o <= load_word;
    end

endmodule : segre_mem_wb_stage

`default_nettype wire

// File: source/segre_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module segre_mem_subsys (
    input  wire logic                         clk_i,
    input  wire logic                         rsn_i,
    // Memory request
    input  wire logic                         is_load_i,
    input  wire logic                         is_store_i,
    input  wire logic                         is_alu_i,
    input  wire logic [`WORD_SIZE-1:0]        addr_i,
    input  wire logic [`WORD_SIZE-1:0]        data_i,
    input  segre_pkg::memop_data_type_e       data_type_i,
    // Line fill
    input  wire logic                         fill_valid_i,
    input  wire logic [`WORD_SIZE-1:0]        fill_addr_i,
    input  wire logic [`WORD_SIZE-1:0]        fill_data_i,
    // Load result and stall
    output logic                              load_valid_o,
    output logic [`WORD_SIZE-1:0]             load_data_o,
    output logic                              load_miss_o,
    output logic                              stall_o
);

    import segre_pkg::*;

    // Request stage outputs
    logic                  req_is_load;
    logic                  req_is_store;
    logic                  req_is_alu;
    mem_addr_u             req_addr;
    logic [`WORD_SIZE-1:0] req_data;
    memop_data_type_e      req_type;
    logic                  req_hit;

    // Store buffer to writeback and data array
    logic [`WORD_BYTES-1:0] fwd_mask;
    logic [`WORD_SIZE-1:0]  fwd_data;
    logic                   drain_we;
    mem_addr_u              drain_addr;
    logic [`WORD_SIZE-1:0]  drain_data;
    memop_data_type_e       drain_type;

    logic [`WORD_SIZE-1:0] cache_word;

    segre_mem_req_stage u_req_stage (
        .clk_i        (clk_i),
        .rsn_i        (rsn_i),
        .is_load_i    (is_load_i),
        .is_store_i   (is_store_i),
        .is_alu_i     (is_alu_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .data_type_i  (data_type_i),
        .stall_i      (stall_o),
        .fill_valid_i (fill_valid_i),
        .fill_addr_i  (fill_addr_i),
        .is_load_o    (req_is_load),
        .is_store_o   (req_is_store),
        .is_alu_o     (req_is_alu),
        .addr_o       (req_addr),
        .data_o       (req_data),
        .data_type_o  (req_type),
        .cache_hit_o  (req_hit)
    );

    segre_store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .rsn_i          (rsn_i),
        .is_load_i      (req_is_load),
        .is_store_i     (req_is_store),
        .is_alu_i       (req_is_alu),
        .addr_i         (req_addr),
        .data_i         (req_data),
        .data_type_i    (req_type),
        .is_hit_i       (req_hit),
        .forward_mask_o (fwd_mask),
        .forward_data_o (fwd_data),
        .drain_we_o     (drain_we),
        .drain_addr_o   (drain_addr),
        .drain_data_o   (drain_data),
        .drain_type_o   (drain_type),
        .is_draining_o  (stall_o)
    );

    segre_dcache_data u_dcache_data (
        .clk_i        (clk_i),
        .rsn_i        (rsn_i),
        .rd_index_i   (req_addr.fields.index),
        .drain_we_i   (drain_we),
        .drain_addr_i (drain_addr),
        .drain_data_i (drain_data),
        .drain_type_i (drain_type),
        .fill_valid_i (fill_valid_i),
        .fill_addr_i  (fill_addr_i),
        .fill_data_i  (fill_data_i),
        .rd_data_o    (cache_word)
    );

    segre_mem_wb_stage u_wb_stage (
        .clk_i          (clk_i),
        .rsn_i          (rsn_i),
        .is_load_i      (req_is_load),
        .cache_hit_i    (req_hit),
        .addr_i         (req_addr),
        .data_type_i    (req_type),
        .cache_data_i   (cache_word),
        .forward_mask_i (fwd_mask),
        .forward_data_i (fwd_data),
        .load_valid_o   (load_valid_o),
        .load_miss_o    (load_miss_o),
        .load_data_o    (load_data_o)
    );

endmodule : segre_mem_subsys

`default_nettype wire

// File: testbench/tb_segre_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "segre_defines.svh"

module tb_segre_mem_subsys;

    import segre_pkg::*;

    localparam int WAIT_LIMIT = 40;
    localparam logic [`ADDR_TAG_BITS-1:0] TAG_A = 'h01234;
    localparam logic [`ADDR_TAG_BITS-1:0] TAG_B = 'h0abcd;

    logic                  clk_i;
    logic                  rsn_i;
    logic                  is_load_i;
    logic                  is_store_i;
    logic                  is_alu_i;
    logic [`WORD_SIZE-1:0] addr_i;
    logic [`WORD_SIZE-1:0] data_i;
    memop_data_type_e      data_type_i;
    logic                  fill_valid_i;
    logic [`WORD_SIZE-1:0] fill_addr_i;
    logic [`WORD_SIZE-1:0] fill_data_i;
    logic                  load_valid_o;
    logic [`WORD_SIZE-1:0] load_data_o;
    logic                  load_miss_o;
    logic                  stall_o;

    // Architectural view of the cache lines, stores applied in program order
    logic [7:0]                  mem_bytes [`CACHE_LINES * `WORD_BYTES];
    logic [`ADDR_TAG_BITS-1:0]   line_tag [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]     line_ok = '0;
    // Indexes of the stores sitting in the buffer, oldest first
    logic [`ADDR_INDEX_BITS-1:0] sb_q [$];

    // Operation taken at the coming edge, then the one in the request register
    logic                        nx_load = 1'b0;
    logic                        nx_miss = 1'b0;
    logic                        nx_store_hit = 1'b0;
    logic                        nx_alu = 1'b0;
    logic [`ADDR_INDEX_BITS-1:0] nx_index = '0;
    logic [`WORD_SIZE-1:0]       nx_data = '0;
    logic                        cur_load = 1'b0;
    logic                        cur_miss = 1'b0;
    logic                        cur_store_hit = 1'b0;
    logic                        cur_alu = 1'b0;
    logic [`ADDR_INDEX_BITS-1:0] cur_index = '0;
    logic [`WORD_SIZE-1:0]       cur_data = '0;
    // Expected writeback outputs and stall
    logic                        wb_valid_m = 1'b0;
    logic                        wb_miss_m = 1'b0;
    logic [`WORD_SIZE-1:0]       wb_data_m = '0;
    logic                        mdl_draining = 1'b0;
    logic                        exp_stall = 1'b0;

    int          errors = 0;
    int          err_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned seed_val;

    segre_mem_subsys i_dut (
        .clk_i        (clk_i),
        .rsn_i        (rsn_i),
        .is_load_i    (is_load_i),
        .is_store_i   (is_store_i),
        .is_alu_i     (is_alu_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .data_type_i  (data_type_i),
        .fill_valid_i (fill_valid_i),
        .fill_addr_i  (fill_addr_i),
        .fill_data_i  (fill_data_i),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o),
        .load_miss_o  (load_miss_o),
        .stall_o      (stall_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("** FAIL **");
        $finish;
    endtask

    function automatic logic [31:0] addr_of(input logic [`ADDR_TAG_BITS-1:0] tag,
                                            input int idx, input int off);
        return {tag, idx[`ADDR_INDEX_BITS-1:0], off[`ADDR_BYTE_BITS-1:0]};
    endfunction

    // Distinct bytes for every line address
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return addr ^ 32'ha5c3_5a3c;
    endfunction

    function automatic int size_bytes(input memop_data_type_e ty);
        case (ty)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic line_hit(input mem_addr_u a);
        return line_ok[a.fields.index] && (line_tag[a.fields.index] == a.fields.tag);
    endfunction

    // Zero-extended bytes at the offset
    function automatic logic [31:0] model_load(input mem_addr_u a, input memop_data_type_e ty);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < size_bytes(ty); b++) begin
            r[8*b +: 8] = mem_bytes[a.fields.index * 4 + a.fields.offset + b];
        end
        return r;
    endfunction

    task automatic fill_line(input logic [31:0] addr);
        mem_addr_u a;
        a.raw = addr;
        fill_valid_i = 1'b1;
        fill_addr_i  = addr;
        fill_data_i  = fill_pattern(addr);
        line_ok[a.fields.index]  = 1'b1;
        line_tag[a.fields.index] = a.fields.tag;
        for (int b = 0; b < 4; b++) begin
            mem_bytes[a.fields.index * 4 + b] = fill_data_i[8*b +: 8];
        end
        @(posedge clk_i);
        #1;
        fill_valid_i = 1'b0;
    endtask

    // Drive one request and hold it until an edge with stall_o low takes it
    task automatic issue(input logic ld, input logic st, input logic alu,
                         input logic [31:0] addr, input logic [31:0] data,
                         input memop_data_type_e ty);
        mem_addr_u a;
        int waited;
        a.raw  = addr;
        waited = 0;
        is_load_i   = ld;
        is_store_i  = st;
        is_alu_i    = alu;
        addr_i      = addr;
        data_i      = data;
        data_type_i = ty;
        @(negedge clk_i);
        while (stall_o) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("request held by stall_o");
            @(negedge clk_i);
        end
        nx_load      = ld;
        nx_miss      = ld && !line_hit(a);
        nx_data      = ld ? model_load(a, ty) : '0;
        nx_store_hit = st && line_hit(a);
        nx_alu       = alu;
        nx_index     = a.fields.index;
        // Stores that miss are dropped by the DUT as well
        if (nx_store_hit) begin
            for (int b = 0; b < size_bytes(ty); b++) begin
                mem_bytes[a.fields.index * 4 + a.fields.offset + b] = data[8*b +: 8];
            end
        end
        @(posedge clk_i);
        #1;
        is_load_i    = 1'b0;
        is_store_i   = 1'b0;
        is_alu_i     = 1'b0;
        nx_load      = 1'b0;
        nx_miss      = 1'b0;
        nx_store_hit = 1'b0;
        nx_alu       = 1'b0;
    endtask

    task automatic load_from(input logic [31:0] addr, input memop_data_type_e ty);
        issue(1'b1, 1'b0, 1'b0, addr, '0, ty);
    endtask

    task automatic store_to(input logic [31:0] addr, input logic [31:0] data,
                            input memop_data_type_e ty);
        issue(1'b0, 1'b1, 1'b0, addr, data, ty);
    endtask

    // ALU slots until the buffer is empty and the results have settled
    task automatic flush_buffer();
        int guard;
        guard = 0;
        while (sb_q.size() != 0 || cur_store_hit) begin
            guard++;
            if (guard > WAIT_LIMIT) abort_on_timeout("store buffer never emptied");
            issue(1'b0, 1'b0, 1'b1, '0, '0, WORD);
        end
        repeat (3) @(posedge clk_i);
        #1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_base) tests_failed++;
        $display("Test %0d %s: %0d error(s)", tests_run, name, errors - err_base);
        err_base = errors;
    endtask

    // Buffer occupancy, blocking drain and writeback pipeline of the model
    always @(posedge clk_i or negedge rsn_i) begin : model_step
        logic drain_now;
        logic miss_match;
        logic was_full;
        if (!rsn_i) begin
            sb_q.delete();
            mdl_draining = 1'b0;
            cur_load      = 1'b0;
            cur_miss      = 1'b0;
            cur_store_hit = 1'b0;
            cur_alu       = 1'b0;
            wb_valid_m    = 1'b0;
            exp_stall     = 1'b0;
        end else begin
            drain_now  = (sb_q.size() != 0) && (mdl_draining || cur_alu);
            was_full   = (sb_q.size() == `NUM_SB_ENTRIES);
            miss_match = 1'b0;
            if (cur_load && cur_miss) begin
                foreach (sb_q[i]) begin
                    if (sb_q[i] == cur_index) miss_match = 1'b1;
                end
            end
            if (drain_now) void'(sb_q.pop_front());
            if (cur_store_hit) sb_q.push_back(cur_index);
            if (!mdl_draining && (was_full || miss_match)) begin
                mdl_draining = 1'b1;
            end else if (mdl_draining && sb_q.size() == 0) begin
                mdl_draining = 1'b0;
            end
            wb_valid_m    = cur_load;
            wb_miss_m     = cur_miss;
            wb_data_m     = cur_data;
            cur_load      = nx_load;
            cur_miss      = nx_miss;
            cur_store_hit = nx_store_hit;
            cur_alu       = nx_alu;
            cur_index     = nx_index;
            cur_data      = nx_data;
            // A store landing in the last free slot already holds the next request
            exp_stall = mdl_draining || (sb_q.size() == `NUM_SB_ENTRIES)
                     || (cur_store_hit && sb_q.size() == `NUM_SB_ENTRIES - 1);
        end
    end

    // Outputs compared half a cycle after the edge
    assert property (@(negedge clk_i) disable iff (!rsn_i) load_valid_o == wb_valid_m)
        else report_mismatch("load_valid_o", 32'(load_valid_o), 32'(wb_valid_m));
    assert property (@(negedge clk_i) disable iff (!rsn_i)
        load_valid_o |-> (load_miss_o == wb_miss_m))
        else report_mismatch("load_miss_o", 32'(load_miss_o), 32'(wb_miss_m));
    assert property (@(negedge clk_i) disable iff (!rsn_i)
        (load_valid_o && !wb_miss_m) |-> (load_data_o == wb_data_m))
        else report_mismatch("load_data_o", load_data_o, wb_data_m);
    assert property (@(negedge clk_i) disable iff (!rsn_i) stall_o == exp_stall)
        else report_mismatch("stall_o", 32'(stall_o), 32'(exp_stall));

    initial begin
        int idx;
        int off;
        memop_data_type_e ty;
        seed_val     = $urandom(53);
        rsn_i        = 1'b0;
        is_load_i    = 1'b0;
        is_store_i   = 1'b0;
        is_alu_i     = 1'b0;
        addr_i       = '0;
        data_i       = '0;
        data_type_i  = WORD;
        fill_valid_i = 1'b0;
        fill_addr_i  = '0;
        fill_data_i  = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rsn_i = 1'b1;

        // Filled lines read back at every size and offset
        for (int i = 0; i < 4; i++) fill_line(addr_of(TAG_A, i, 0));
        for (int i = 0; i < 4; i++) begin
            load_from(addr_of(TAG_A, i, 0), WORD);
            load_from(addr_of(TAG_A, i, 0), HALF);
            load_from(addr_of(TAG_A, i, 2), HALF);
            for (int o = 0; o < 4; o++) load_from(addr_of(TAG_A, i, o), BYTE);
        end
        load_from(addr_of(TAG_A, 9, 0), WORD);
        flush_buffer();
        finish_test("fill and load");

        // Loads right behind stores see the buffered bytes
        store_to(addr_of(TAG_A, 0, 1), 32'h0000_00ab, BYTE);
        load_from(addr_of(TAG_A, 0, 0), WORD);
        store_to(addr_of(TAG_A, 1, 2), 32'h0000_beef, HALF);
        load_from(addr_of(TAG_A, 1, 2), HALF);
        load_from(addr_of(TAG_A, 1, 3), BYTE);
        // Room for both stores so the load merges two entries
        flush_buffer();
        store_to(addr_of(TAG_A, 2, 0), 32'hcafe_f00d, WORD);
        store_to(addr_of(TAG_A, 2, 0), 32'h0000_0077, BYTE);
        load_from(addr_of(TAG_A, 2, 0), WORD);
        flush_buffer();
        for (int i = 0; i < 3; i++) load_from(addr_of(TAG_A, i, 0), WORD);
        flush_buffer();
        finish_test("store forwarding");

        // Missing stores leave no trace
        store_to(addr_of(TAG_A, 5, 0), 32'h1357_9bdf, WORD);
        store_to(addr_of(TAG_B, 0, 0), 32'h2468_ace0, WORD);
        flush_buffer();
        fill_line(addr_of(TAG_A, 5, 0));
        load_from(addr_of(TAG_A, 5, 0), WORD);
        load_from(addr_of(TAG_A, 0, 0), WORD);
        flush_buffer();
        finish_test("dropped store");

        // Full buffer stalls and the fifth store waits for the drain
        for (int o = 0; o < 4; o++) store_to(addr_of(TAG_A, 3, o), 32'h10 + o, BYTE);
        store_to(addr_of(TAG_A, 1, 0), 32'h5555_aaaa, WORD);
        flush_buffer();
        load_from(addr_of(TAG_A, 3, 0), WORD);
        load_from(addr_of(TAG_A, 1, 0), WORD);
        flush_buffer();
        finish_test("full buffer drain");

        // ALU slots drain one entry each
        store_to(addr_of(TAG_A, 0, 2), 32'h0000_9876, HALF);
        store_to(addr_of(TAG_A, 2, 3), 32'h0000_0042, BYTE);
        issue(1'b0, 1'b0, 1'b1, '0, '0, WORD);
        issue(1'b0, 1'b0, 1'b1, '0, '0, WORD);
        issue(1'b0, 1'b0, 1'b1, '0, '0, WORD);
        load_from(addr_of(TAG_A, 0, 0), WORD);
        load_from(addr_of(TAG_A, 2, 0), WORD);
        flush_buffer();
        finish_test("ALU slot drain");

        // Conflicting miss forces a drain before a random mix
        store_to(addr_of(TAG_A, 3, 0), 32'h0bad_f00d, WORD);
        load_from(addr_of(TAG_B, 3, 0), WORD);
        load_from(addr_of(TAG_A, 3, 0), WORD);
        for (int n = 0; n < 80; n++) begin
            ty  = memop_data_type_e'($urandom_range(0, 2));
            idx = $urandom_range(0, 5);
            case (ty)
                BYTE:    off = $urandom_range(0, 3);
                HALF:    off = 2 * $urandom_range(0, 1);
                default: off = 0;
            endcase
            case ($urandom_range(0, 2))
                0: load_from(addr_of(($urandom_range(0, 3) == 0) ? TAG_B : TAG_A, idx, off), ty);
                1: store_to(addr_of(($urandom_range(0, 3) == 0) ? TAG_B : TAG_A, idx, off),
                            $urandom, ty);
                default: issue(1'b0, 1'b0, 1'b1, $urandom, $urandom, ty);
            endcase
        end
        flush_buffer();
        finish_test("miss drain and random mix");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_segre_mem_subsys

`default_nettype wire

// File: build.f
+incdir+common
common/segre_pkg.sv
source/segre_mem_req_stage.sv
store_buffer/segre_store_buffer.sv
source/segre_dcache_data.sv
source/segre_mem_wb_stage.sv
source/segre_mem_subsys.sv
testbench/tb_segre_mem_subsys.sv

// File: Makefile
SIM        = verilator
TOP        = tb_segre_mem_subsys
RTL_TOP    = segre_mem_subsys
FILELIST   = build.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_MSG   = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
